//--- verilog/weights_settings.svh
`ifndef WEIGHTS_SETTINGS_SVH
`define WEIGHTS_SETTINGS_SVH

////////////////////////////////////////////////////////////
// tile geometry
////////////////////////////////////////////////////////////

`define WT_ROW_NUM_MODE0 64     // output channels per tile, mode 0
`define WT_ROW_NUM_MODE1 128    // output channels per tile, mode 1

// largest single DDR read burst, in words
`define WT_DDR_CMD_WORDS 32

////////////////////////////////////////////////////////////
// weight buffer
////////////////////////////////////////////////////////////

`define WT_WORD_W 64
`define WT_BUF_DEPTH 1024       // also the max words per tile
`define WT_BUF_ADR_W 10

`endif

//--- verilog/weights_pkg.sv
`include "weights_settings.svh"

package weights_pkg;

  // conv mode, selects rows per output-channel tile
  typedef enum logic [3:0] {
    mode_64rows  = 4'd0,
    mode_128rows = 4'd1
  } conv_mode_t;

  // DDR side
  typedef logic [31:0] ddr_adr_t;    // word address
  typedef logic [15:0] ddr_len_t;    // burst length in words

  // buffer side
  typedef logic [`WT_WORD_W-1:0]    wt_word_t;
  typedef logic [`WT_BUF_ADR_W-1:0] buf_adr_t;

endpackage

//--- verilog/weights_buf.sv
`timescale 1ns/1ps
`include "weights_settings.svh"

module weights_buf (
  input  logic                  clk,
  input  logic                  wr_en,
  input  weights_pkg::buf_adr_t wr_adr,
  input  weights_pkg::wt_word_t wr_data,
  input  logic                  rd_en,
  input  weights_pkg::buf_adr_t rd_adr,
  output weights_pkg::wt_word_t rd_data
);
  import weights_pkg::*;

  wt_word_t mem [`WT_BUF_DEPTH];

  ////////////////////////////////////////////////////////////
  // write port, loader side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_adr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // read port, compute side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_adr];  // holds when rd_en is low
    end
  end

endmodule

//--- verilog/weights_tile_seq.sv
`timescale 1ns/1ps

module weights_tile_seq (
  input  logic clk,
  input  logic reset,
  input  logic layer_run,
  input  logic load_fin,
  input  logic compute_done,
  output logic load_start,
  output logic buf_ready
);

  typedef enum logic [1:0] {
    s_idle    = 2'd0,
    s_loading = 2'd1,
    s_ready   = 2'd2
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_nxt;
  logic       start_now;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  assign start_now = (state == s_idle) && layer_run;

  always_comb begin
    state_nxt = state;
    case (state)
      s_idle: begin
        if (layer_run) begin
          state_nxt = s_loading;
        end
      end
      s_loading: begin
        if (load_fin) begin
          state_nxt = s_ready;  // tile fully in buffer
        end
      end
      s_ready: begin
        // compute array owns the buffer until it lets go
        if (compute_done) begin
          state_nxt = s_idle;
        end
      end
      default: begin
        state_nxt = s_idle;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state and start strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // single-cycle pulse on entry to loading
  always_ff @(posedge clk) begin
    if (reset) begin
      load_start <= 1'b0;
    end else begin
      load_start <= start_now;
    end
  end

  assign buf_ready = (state == s_ready);  // rises the cycle after load_fin

endmodule

//--- verilog/weights_load_ctrl.sv
`timescale 1ns/1ps
`include "weights_settings.svh"

module weights_load_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load_start,
  input  logic                   ddr_cmd_ready,
  input  logic                   ddr_rd_data_valid,
  input  weights_pkg::conv_mode_t mode_init,
  input  logic [31:0]            nkk_init,
  input  logic [15:0]            of_init,
  input  weights_pkg::ddr_adr_t  layer_base_adr_init,
  output logic                   ddr_rd_en,
  output weights_pkg::ddr_adr_t  ddr_rd_adr,
  output weights_pkg::ddr_adr_t  ddr_cmd_adr,
  output weights_pkg::ddr_len_t  ddr_cmd_len,
  output logic                   ddr_cmd_valid,
  output logic                   buf_wr_en,
  output weights_pkg::buf_adr_t  buf_wr_adr,
  output logic                   load_fin,
  output logic                   loading
);
  import weights_pkg::*;

  // layer config
  logic [31:0] nkk;          // words per tile
  logic [15:0] of_num;       // output channels in layer
  ddr_adr_t    layer_base;
  logic [15:0] row_num;      // output channels per tile

  // command generation
  logic        tile_active;  // commands still to send for this tile
  logic        cmd_lock;
  logic        issue;
  logic [31:0] words_left;
  logic        cmd_last;     // final command of the tile is out
  logic [31:0] cmd_word_base;

  // tile position in the layer
  logic [15:0] tile_start;
  logic [31:0] tile_base;
  logic        tile_wrap;

  // returning words
  ddr_len_t    shadow_len;
  ddr_len_t    cmd_word_cnt; // 1-based within the command
  logic        cmd_words_done;
  buf_adr_t    buf_word_cnt;
  logic        tile_last_word;
  logic        all_cmds_sent;

  ////////////////////////////////////////////////////////////
  // config sampling, held once reset drops
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      nkk        <= nkk_init;
      of_num     <= of_init;
      layer_base <= layer_base_adr_init;
      row_num    <= (mode_init == mode_128rows) ? 16'(`WT_ROW_NUM_MODE1)
                                                : 16'(`WT_ROW_NUM_MODE0);
    end
  end

  ////////////////////////////////////////////////////////////
  // command issue
  ////////////////////////////////////////////////////////////

  // one burst in flight at a time
  assign issue = !loading && tile_active && ddr_cmd_ready && !cmd_lock;

  assign words_left = nkk - cmd_word_base;

  always_ff @(posedge clk) begin
    if (reset) begin
      tile_active <= 1'b0;
    end else if (load_start) begin
      tile_active <= 1'b1;
    end else if (cmd_last) begin
      tile_active <= 1'b0;
    end
  end

  // blocks a second issue before the first valid shows up
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_lock <= 1'b0;
    end else if (ddr_cmd_valid) begin
      cmd_lock <= 1'b0;
    end else if (issue) begin
      cmd_lock <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ddr_cmd_valid <= 1'b0;
    end else begin
      ddr_cmd_valid <= issue;
    end
  end

  // command fields, one cycle behind the issue decision
  always_ff @(posedge clk) begin
    if (issue) begin
      ddr_cmd_adr <= layer_base + tile_base + cmd_word_base;
      ddr_cmd_len <= (words_left > 32'(`WT_DDR_CMD_WORDS)) ? ddr_len_t'(`WT_DDR_CMD_WORDS)
                                                          : ddr_len_t'(words_left);
    end
  end

  assign ddr_rd_en  = ddr_cmd_valid;
  assign ddr_rd_adr = ddr_cmd_adr;  // first word of the burst

  assign cmd_last  = ddr_cmd_valid && (cmd_word_base + 32'(ddr_cmd_len) >= nkk);
  assign tile_wrap = cmd_last &&
                     ({1'b0, tile_start} + {1'b0, row_num} >= {1'b0, of_num});

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_word_base <= '0;
    end else if (ddr_cmd_valid) begin
      if (cmd_last) begin
        cmd_word_base <= '0;
      end else begin
        cmd_word_base <= cmd_word_base + 32'(ddr_cmd_len);
      end
    end
  end

  // tile counters, back to tile 0 after the last one
  always_ff @(posedge clk) begin
    if (reset) begin
      tile_start <= '0;
      tile_base  <= '0;
    end else if (cmd_last) begin
      if (tile_wrap) begin
        tile_start <= '0;
        tile_base  <= '0;
      end else begin
        tile_start <= tile_start + row_num;
        tile_base  <= tile_base + nkk;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // returning words into the buffer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ddr_cmd_valid) begin
      shadow_len <= ddr_cmd_len;
    end
  end

  assign buf_wr_en      = loading && ddr_rd_data_valid;
  assign cmd_words_done = buf_wr_en && (cmd_word_cnt == shadow_len);

  always_ff @(posedge clk) begin
    if (reset) begin
      loading <= 1'b0;
    end else if (ddr_cmd_valid) begin
      loading <= 1'b1;
    end else if (cmd_words_done) begin
      loading <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_word_cnt <= ddr_len_t'(1);
    end else if (buf_wr_en) begin
      if (cmd_words_done) begin
        cmd_word_cnt <= ddr_len_t'(1);
      end else begin
        cmd_word_cnt <= cmd_word_cnt + ddr_len_t'(1);
      end
    end
  end

  assign tile_last_word = buf_wr_en && (32'(buf_word_cnt) == nkk - 32'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_word_cnt <= '0;
    end else if (buf_wr_en) begin
      if (tile_last_word) begin
        buf_word_cnt <= '0;
      end else begin
        buf_word_cnt <= buf_word_cnt + buf_adr_t'(1);
      end
    end
  end

  assign buf_wr_adr = buf_word_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      all_cmds_sent <= 1'b0;
    end else if (cmd_last) begin
      all_cmds_sent <= 1'b1;
    end else if (load_fin) begin
      all_cmds_sent <= 1'b0;
    end
  end

  assign load_fin = all_cmds_sent && tile_last_word;  // same cycle as last write

endmodule

//--- verilog/weights_load_top.sv
`timescale 1ns/1ps

module weights_load_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    layer_run,
  input  logic                    compute_done,
  input  weights_pkg::conv_mode_t mode_init,
  input  logic [31:0]             nkk_init,
  input  logic [15:0]             of_init,
  input  weights_pkg::ddr_adr_t   layer_base_adr_init,
  input  logic                    ddr_cmd_ready,
  input  logic                    ddr_rd_data_valid,
  input  weights_pkg::wt_word_t   ddr_rd_data,
  output logic                    ddr_rd_en,
  output weights_pkg::ddr_adr_t   ddr_rd_adr,
  output weights_pkg::ddr_adr_t   ddr_cmd_adr,
  output weights_pkg::ddr_len_t   ddr_cmd_len,
  output logic                    ddr_cmd_valid,
  output logic                    buf_ready,
  input  logic                    buf_rd_en,
  input  weights_pkg::buf_adr_t   buf_rd_adr,
  output weights_pkg::wt_word_t   buf_rd_data,
  output logic                    loading,
  output logic                    load_fin
);
  import weights_pkg::*;

  logic     load_start;
  logic     buf_wr_en;
  buf_adr_t buf_wr_adr;

  ////////////////////////////////////////////////////////////
  // tile sequencing
  ////////////////////////////////////////////////////////////

  weights_tile_seq u_tile_seq (
    .clk          (clk),
    .reset        (reset),
    .layer_run    (layer_run),
    .load_fin     (load_fin),
    .compute_done (compute_done),
    .load_start   (load_start),
    .buf_ready    (buf_ready)
  );

  // DDR command generation and buffer writes
  weights_load_ctrl u_load_ctrl (
    .clk                 (clk),
    .reset               (reset),
    .load_start          (load_start),
    .ddr_cmd_ready       (ddr_cmd_ready),
    .ddr_rd_data_valid   (ddr_rd_data_valid),
    .mode_init           (mode_init),
    .nkk_init            (nkk_init),
    .of_init             (of_init),
    .layer_base_adr_init (layer_base_adr_init),
    .ddr_rd_en           (ddr_rd_en),
    .ddr_rd_adr          (ddr_rd_adr),
    .ddr_cmd_adr         (ddr_cmd_adr),
    .ddr_cmd_len         (ddr_cmd_len),
    .ddr_cmd_valid       (ddr_cmd_valid),
    .buf_wr_en           (buf_wr_en),
    .buf_wr_adr          (buf_wr_adr),
    .load_fin            (load_fin),
    .loading             (loading)
  );

  weights_buf u_buf (
    .clk     (clk),
    .wr_en   (buf_wr_en),
    .wr_adr  (buf_wr_adr),
    .wr_data (ddr_rd_data),  // straight from DDR
    .rd_en   (buf_rd_en),
    .rd_adr  (buf_rd_adr),
    .rd_data (buf_rd_data)
  );

endmodule

//--- verif/weights_load_assertions.sv
`timescale 1ns/1ps

module weights_load_assertions (
  input logic clk,
  input logic reset,
  input logic ddr_cmd_valid,
  input logic loading,
  input logic load_fin,
  input logic buf_ready
);

  ////////////////////////////////////////////////////////////
  // DDR command side
  ////////////////////////////////////////////////////////////

  no_cmd_while_loading: assert property (@(posedge clk) disable iff (reset)
    !(ddr_cmd_valid && loading)) else $error("ddr_cmd_valid while a burst is loading");

  cmd_single_pulse: assert property (@(posedge clk) disable iff (reset)
    ddr_cmd_valid |=> !ddr_cmd_valid) else $error("ddr_cmd_valid longer than one cycle");

  // buffer side
  fin_then_ready: assert property (@(posedge clk) disable iff (reset)
    load_fin |=> (buf_ready && !loading)) else $error("no ready buffer after load_fin");

  ready_not_loading: assert property (@(posedge clk) disable iff (reset)
    loading |-> !buf_ready) else $error("buf_ready high during a load");

endmodule

bind weights_load_top weights_load_assertions u_assertions (
  .clk           (clk),
  .reset         (reset),
  .ddr_cmd_valid (ddr_cmd_valid),
  .loading       (loading),
  .load_fin      (load_fin),
  .buf_ready     (buf_ready)
);

//--- verif/tb_weights_load.sv
`timescale 1ns/1ps
`include "weights_settings.svh"

module tb_weights_load;
  import weights_pkg::*;

  localparam logic [31:0] SEED = 32'h8467_9d9c;
  localparam int WAIT_LIMIT = 20000;  // cycles per wait loop

  logic        clk = 1'b0;
  logic        reset;
  logic        layer_run;
  logic        compute_done;
  conv_mode_t  mode_init;
  logic [31:0] nkk_init;
  logic [15:0] of_init;
  ddr_adr_t    layer_base_adr_init;
  logic        ddr_cmd_ready = 1'b0;
  logic        ddr_rd_data_valid = 1'b0;
  wt_word_t    ddr_rd_data = '0;
  logic        buf_rd_en;
  buf_adr_t    buf_rd_adr;
  logic        ddr_rd_en;
  ddr_adr_t    ddr_rd_adr;
  ddr_adr_t    ddr_cmd_adr;
  ddr_len_t    ddr_cmd_len;
  logic        ddr_cmd_valid;
  logic        buf_ready;
  wt_word_t    buf_rd_data;
  logic        loading;
  logic        load_fin;

  int          cfg_nkk;      // layer as the checkers see it
  int          cfg_tiles;
  ddr_adr_t    cfg_base;
  bit          cmd_allowed;
  logic [31:0] rng_ddr = SEED;
  logic [31:0] rng_cpu;
  int          cmd_errs;
  int          buf_errs;
  int          timeouts;
  ddr_adr_t    pend_q[$];    // word addresses still owed by DDR
  int          cmd_k;
  int          tile_t;
  int          word_cnt;
  int          cmd_total;
  int          ready_hold;
  int          gap;
  logic        ready_prev;

  weights_load_top DUT (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // DDR content, a function of the word address
  function automatic wt_word_t ddr_word(input ddr_adr_t a);
    return {a ^ 32'hc3a5_5a3c, a * 32'h9e37_79b9};
  endfunction

  function automatic int check_val(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  function automatic void check_idle_outputs();
    buf_errs += check_val("ddr_cmd_valid", 64'(ddr_cmd_valid), 64'd0);
    buf_errs += check_val("ddr_rd_en", 64'(ddr_rd_en), 64'd0);
    buf_errs += check_val("loading", 64'(loading), 64'd0);
    buf_errs += check_val("load_fin", 64'(load_fin), 64'd0);
    buf_errs += check_val("buf_ready", 64'(buf_ready), 64'd0);
  endfunction

  ////////////////////////////////////////////////////////////
  // DDR model and command reference
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : ddr_model
    logic     exp_fin;
    ddr_adr_t exp_adr;
    int       rem;
    rng_ddr = xorshift(rng_ddr);
    if (ready_hold == 0) begin  // ready in random stretches
      ddr_cmd_ready <= (rng_ddr[3:0] > 4'd5);
      ready_hold = int'(rng_ddr[6:4]) + 1;
    end
    ready_hold--;
    if (reset) begin
      cmd_k = 0;
      tile_t = 0;
      word_cnt = 0;
      cmd_total = 0;
      gap = 0;
      pend_q.delete();
      ddr_rd_data_valid <= 1'b0;
    end else begin
      cmd_errs += check_val("ddr_rd_en", 64'(ddr_rd_en), 64'(ddr_cmd_valid));
      if (ddr_cmd_valid === 1'b1) begin
        if (!cmd_allowed || ready_prev !== 1'b1 || pend_q.size() != 0) begin
          $display("command at %0t without layer_run, ready or drained burst", $time);
          cmd_errs++;
        end
        exp_adr = cfg_base + ddr_adr_t'(tile_t * cfg_nkk + `WT_DDR_CMD_WORDS * cmd_k);
        rem = cfg_nkk - `WT_DDR_CMD_WORDS * cmd_k;
        rem = (rem > `WT_DDR_CMD_WORDS) ? `WT_DDR_CMD_WORDS : rem;
        cmd_errs += check_val("ddr_cmd_adr", 64'(ddr_cmd_adr), 64'(exp_adr));
        cmd_errs += check_val("ddr_cmd_len", 64'(ddr_cmd_len), 64'(rem));
        cmd_errs += check_val("ddr_rd_adr", 64'(ddr_rd_adr), 64'(exp_adr));
        for (int i = 0; i < int'(ddr_cmd_len); i++) begin
          pend_q.push_back(ddr_cmd_adr + ddr_adr_t'(i));
        end
        cmd_total++;
        cmd_k++;
        if (`WT_DDR_CMD_WORDS * cmd_k >= cfg_nkk) begin  // next tile, wrap after the last
          cmd_k = 0;
          tile_t = (tile_t + 1) % cfg_tiles;
        end
      end
      exp_fin = 1'b0;
      if (ddr_rd_data_valid === 1'b1) begin
        cmd_errs += check_val("loading", 64'(loading), 64'd1);
        word_cnt++;
        exp_fin = (word_cnt == cfg_nkk);  // nkk-th write of the tile
        if (exp_fin) word_cnt = 0;
      end
      cmd_errs += check_val("load_fin", 64'(load_fin), 64'(exp_fin));
      if (gap > 0) begin
        gap--;
        ddr_rd_data_valid <= 1'b0;
      end else if (pend_q.size() > 0) begin
        ddr_rd_data_valid <= 1'b1;
        ddr_rd_data <= ddr_word(pend_q.pop_front());
        gap = int'(rng_ddr[9:8]);
      end else begin
        ddr_rd_data_valid <= 1'b0;
      end
    end
    ready_prev = ddr_cmd_ready;  // level during the cycle just ended
  end

  ////////////////////////////////////////////////////////////
  // compute side
  ////////////////////////////////////////////////////////////

  task automatic wait_load_fin(output bit ok);
    int cnt;
    cnt = 0;
    ok = 1'b0;
    while (!ok && cnt < WAIT_LIMIT) begin
      @(posedge clk);
      cnt++;
      if (load_fin === 1'b1) begin
        ok = 1'b1;
        buf_errs += check_val("buf_ready", 64'(buf_ready), 64'd0);
      end
    end
    if (!ok) begin
      $display("timeout at %0t, no load_fin within %0d cycles", $time, WAIT_LIMIT);
      timeouts++;
    end
  endtask

  // registered read, data lags the address by two sampling edges
  task automatic read_tile(input int t);
    for (int i = 0; i < cfg_nkk + 2; i++) begin
      buf_errs += check_val("buf_ready", 64'(buf_ready), 64'd1);
      if (i >= 2) begin
        buf_errs += check_val("buf_rd_data", buf_rd_data,
                              ddr_word(cfg_base + ddr_adr_t'(t * cfg_nkk + i - 2)));
      end
      buf_rd_en <= (i < cfg_nkk);
      buf_rd_adr <= buf_adr_t'(i);
      @(posedge clk);
    end
  endtask

  task automatic release_buf(input bit last);
    rng_cpu = xorshift(rng_cpu);
    repeat (int'(rng_cpu[3:0])) @(posedge clk);
    compute_done <= 1'b1;
    if (last) layer_run <= 1'b0;
    @(posedge clk);
    compute_done <= 1'b0;
    buf_errs += check_val("buf_ready", 64'(buf_ready), 64'd1);
    @(posedge clk);
    buf_errs += check_val("buf_ready", 64'(buf_ready), 64'd0);
  endtask

  task automatic run_phase(input conv_mode_t mode, input int nkk, input int of_num,
                           input ddr_adr_t base);
    int rows;
    bit ok;
    rows = (mode == mode_128rows) ? `WT_ROW_NUM_MODE1 : `WT_ROW_NUM_MODE0;
    cfg_nkk = nkk;
    cfg_tiles = (of_num + rows - 1) / rows;
    cfg_base = base;
    cmd_allowed = 1'b0;
    @(posedge clk);
    reset <= 1'b1;
    mode_init <= mode;
    nkk_init <= 32'(nkk);
    of_init <= 16'(of_num);
    layer_base_adr_init <= base;
    for (int c = 0; c < 8; c++) begin
      @(posedge clk);
      if (c > 0) check_idle_outputs();
    end
    reset <= 1'b0;
    repeat (12) begin  // layer_run still low
      @(posedge clk);
      check_idle_outputs();
    end
    layer_run <= 1'b1;
    cmd_allowed = 1'b1;
    for (int t = 0; t < cfg_tiles + 2; t++) begin
      wait_load_fin(ok);
      if (!ok) return;
      @(posedge clk);
      buf_errs += check_val("buf_ready", 64'(buf_ready), 64'd1);
      read_tile(t % cfg_tiles);
      release_buf(t == cfg_tiles + 1);
    end
    repeat (10) begin
      @(posedge clk);
      check_idle_outputs();
    end
    buf_errs += check_val("command count", 64'(cmd_total),
                          64'((cfg_tiles + 2) * ((nkk + `WT_DDR_CMD_WORDS - 1) / 32)));
  endtask

  initial begin
    reset = 1'b1;
    layer_run = 1'b0;
    compute_done = 1'b0;
    mode_init = mode_64rows;
    nkk_init = '0;
    of_init = '0;
    layer_base_adr_init = '0;
    buf_rd_en = 1'b0;
    buf_rd_adr = '0;
    rng_cpu = SEED ^ 32'h5bd1_e995;
    run_phase(mode_64rows, 100, 200, 32'h0010_0000);
    if (timeouts == 0) run_phase(mode_128rows, 70, 300, 32'h0200_0400);
    $display("errors: command %0d, buffer %0d, timeout %0d", cmd_errs, buf_errs, timeouts);
    if (cmd_errs + buf_errs + timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/weights_pkg.sv
verilog/weights_buf.sv
verilog/weights_tile_seq.sv
verilog/weights_load_ctrl.sv
verilog/weights_load_top.sv
verif/weights_load_assertions.sv
verif/tb_weights_load.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
  --top-module tb_weights_load -o tb_weights_load \
  && ./obj_dir/tb_weights_load > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^Simulation finished: PASS$" sim.log && exit 0 || exit 1
